//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= sonata_reg_tb
FILELIST  ?= src.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/sonata_reg_chk.sv
`timescale 1ns/1ps
`include "sonata_consts.svh"

module sonata_reg_chk (
   input logic        usb_clk,
   input logic        reset_i,
   input logic [7:0]  reg_address_i,
   input logic        reg_write_i,
   input logic        reg_addrvalid_i,
   input logic        crypt_start_o,
   input logic        lb1_wr_o,
   input logic        lb1_rd_o,
   input logic        lb2_wr_o,
   input logic        lb2_rd_o
);

   logic go_wr;
   logic any_strobe;
   integer assert_fail_cnt = 0;   // failed assertions so far

   assign go_wr = reg_addrvalid_i && reg_write_i && (reg_address_i == `SONATA_REG_CRYPT_GO);
   assign any_strobe = crypt_start_o | lb1_wr_o | lb1_rd_o | lb2_wr_o | lb2_rd_o;

   a_start_single: assert property (@(posedge usb_clk) disable iff (reset_i)
      crypt_start_o |=> !crypt_start_o)
   else begin
      assert_fail_cnt++;
      $error("start strobe held two cycles");
   end
   a_lb1_single: assert property (@(posedge usb_clk) disable iff (reset_i)
      (lb1_wr_o | lb1_rd_o) |=> !(lb1_wr_o | lb1_rd_o))
   else begin
      assert_fail_cnt++;
      $error("port 1 strobe held");
   end
   a_lb2_single: assert property (@(posedge usb_clk) disable iff (reset_i)
      (lb2_wr_o | lb2_rd_o) |=> !(lb2_wr_o | lb2_rd_o))
   else begin
      assert_fail_cnt++;
      $error("port 2 strobe held");
   end
   a_start_follows_go: assert property (@(posedge usb_clk) disable iff (reset_i)
      go_wr |=> crypt_start_o)
   else begin
      assert_fail_cnt++;
      $error("no start after go write");
   end
   a_reset_low: assert property (@(posedge usb_clk)
      reset_i |=> !any_strobe)
   else begin
      assert_fail_cnt++;
      $error("strobe high after reset");
   end

endmodule

bind sonata_reg_top sonata_reg_chk chk0 (.*);

//--- bench/sonata_reg_monitor.sv
`timescale 1ns/1ps
`include "sonata_consts.svh"

module sonata_reg_monitor (
   input logic         usb_clk,
   input logic         reset_i,
   input logic [7:0]   reg_address_i,
   input logic [6:0]   reg_bytecnt_i,
   input logic [7:0]   write_data_i,
   input logic [7:0]   read_data_o,
   input logic         reg_read_i,
   input logic         reg_write_i,
   input logic         reg_addrvalid_i,
   input logic         user_led_o,
   input logic [127:0] crypt_key_o,
   input logic [127:0] crypt_textin_o,
   input logic         crypt_start_o,
   input logic         crypt_busy_i,
   input logic         crypt_done_i,
   input logic [127:0] crypt_textout_i,
   input logic [127:0] crypt_cipherout_i,
   input logic [31:0]  lb_addr_o,
   input logic [31:0]  lb1_wr_d_o,
   input logic [31:0]  lb2_wr_d_o,
   input logic         lb1_wr_o,
   input logic         lb1_rd_o,
   input logic         lb2_wr_o,
   input logic         lb2_rd_o,
   input logic [31:0]  lb1_rd_d_i,
   input logic         lb1_rd_rdy_i,
   input logic [31:0]  lb2_rd_d_i,
   input logic         lb2_rd_rdy_i
);

   // expected register state
   logic         exp_led;
   logic [127:0] exp_key, exp_text, exp_tout, exp_cout;
   logic [31:0]  exp_addr, exp_wr1, exp_wr2, exp_rd1, exp_rd2;
   logic [3:0]   exp_action;
   logic [3:0]   strb_exp;     // port strobes due this cycle
   logic         busy_prev, done_prev, go_prev;
   logic         wr_en;
   logic [7:0]   exp_rd;
   string        cur_name;
   integer       err_cnt = 0, test_err = 0, test_cnt = 0, fail_cnt = 0;

   function automatic logic [7:0] expected_read(input logic [7:0] a, input logic [6:0] bc);
      case (a)
         `SONATA_REG_USER_LED:        return {7'b0, exp_led};
         `SONATA_REG_CRYPT_TYPE:      return 8'h02;
         `SONATA_REG_CRYPT_REV:       return 8'h04;
         `SONATA_REG_IDENTIFY:        return 8'h2e;
         `SONATA_REG_CRYPT_GO:        return {7'b0, busy_prev};
         `SONATA_REG_CRYPT_KEY:       return exp_key[bc*8 +: 8];
         `SONATA_REG_CRYPT_TEXTIN:    return exp_text[bc*8 +: 8];
         `SONATA_REG_CRYPT_TEXTOUT:   return exp_tout[bc*8 +: 8];
         `SONATA_REG_CRYPT_CIPHEROUT: return exp_cout[bc*8 +: 8];
         `SONATA_REG_LB_DATA1:        return exp_rd1[bc*8 +: 8];
         `SONATA_REG_LB_DATA2:        return exp_rd2[bc*8 +: 8];
         default:                     return 8'h00;   // write-only or unmapped
      endcase
   endfunction

   task automatic check_value(input string what, input logic [127:0] exp, input logic [127:0] act);
      if (exp !== act) begin
         err_cnt++;
         test_err++;
         $display("FAIL %s %s expected %h actual %h", cur_name, what, exp, act);
      end
   endtask

   task automatic begin_test(input string name);
      cur_name = name;
      test_err = 0;
   endtask

   task automatic end_test();
      test_cnt++;
      if (test_err == 0) begin
         $display("test %s ok", cur_name);
      end else begin
         fail_cnt++;
         $display("test %s failed with %0d errors", cur_name, test_err);
      end
   endtask

   task automatic report_summary();
      $display("summary %0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
   endtask

   ////////////////////////////////////////////////////////////
   // compare mid-cycle, then advance the model
   ////////////////////////////////////////////////////////////

   always @(negedge usb_clk) begin
      if (reset_i) begin
         exp_led    = 1'b0;
         exp_action = 4'h0;
         strb_exp   = 4'h0;
         busy_prev  = 1'b0;
         done_prev  = 1'b0;
         go_prev    = 1'b0;
      end else begin
         exp_rd = (reg_addrvalid_i && reg_read_i) ? expected_read(reg_address_i, reg_bytecnt_i)
                                                  : 8'h00;
         check_value("read data", exp_rd, read_data_o);
         check_value("start strobe", go_prev, crypt_start_o);
         check_value("port strobes", strb_exp, {lb2_rd_o, lb2_wr_o, lb1_rd_o, lb1_wr_o});
         if (strb_exp != 4'h0) begin
            check_value("lb address", exp_addr, lb_addr_o);
            check_value("lb1 write data", exp_wr1, lb1_wr_d_o);
            check_value("lb2 write data", exp_wr2, lb2_wr_d_o);
         end
         check_value("key output", exp_key, crypt_key_o);
         check_value("text output", exp_text, crypt_textin_o);
         check_value("user led", exp_led, user_led_o);

         wr_en    = reg_addrvalid_i && reg_write_i;
         go_prev  = wr_en && (reg_address_i == `SONATA_REG_CRYPT_GO);
         strb_exp = (wr_en && reg_address_i == `SONATA_REG_LB_ADDR && reg_bytecnt_i == 3)
                    ? exp_action : 4'h0;
         busy_prev = crypt_busy_i;
         if (crypt_done_i && !done_prev) begin   // done rising edge
            exp_tout = crypt_textout_i;
            exp_cout = crypt_cipherout_i;
         end
         done_prev = crypt_done_i;
         if (lb1_rd_rdy_i) exp_rd1 = lb1_rd_d_i;
         if (lb2_rd_rdy_i) exp_rd2 = lb2_rd_d_i;
         if (wr_en) begin
            case (reg_address_i)
               `SONATA_REG_USER_LED:     exp_led = write_data_i[0];
               `SONATA_REG_CRYPT_KEY:    exp_key[reg_bytecnt_i*8 +: 8] = write_data_i;
               `SONATA_REG_CRYPT_TEXTIN: exp_text[reg_bytecnt_i*8 +: 8] = write_data_i;
               `SONATA_REG_LB_DATA1:     exp_wr1[reg_bytecnt_i*8 +: 8] = write_data_i;
               `SONATA_REG_LB_DATA2:     exp_wr2[reg_bytecnt_i*8 +: 8] = write_data_i;
               `SONATA_REG_LB_ADDR:      exp_addr[reg_bytecnt_i*8 +: 8] = write_data_i;
               `SONATA_REG_LB_ACTION:    exp_action = write_data_i[3:0];
               default: ;
            endcase
         end
      end
   end

endmodule

//--- bench/sonata_reg_tb.sv
`timescale 1ns/1ps
`include "sonata_consts.svh"

module sonata_reg_tb;

   logic         usb_clk, reset_i;
   logic [7:0]   reg_address_i, write_data_i, read_data_o;
   logic [6:0]   reg_bytecnt_i;
   logic         reg_read_i, reg_write_i, reg_addrvalid_i;
   logic         user_led_o, crypt_start_o, crypt_busy_i, crypt_done_i;
   logic [127:0] crypt_key_o, crypt_textin_o, crypt_textout_i, crypt_cipherout_i;
   logic [31:0]  lb_addr_o, lb1_wr_d_o, lb2_wr_d_o, lb1_rd_d_i, lb2_rd_d_i;
   logic         lb1_wr_o, lb1_rd_o, lb2_wr_o, lb2_rd_o, lb1_rd_rdy_i, lb2_rd_rdy_i;
   integer       seed, i, k, n1, n2;
   logic [3:0]   act;
   logic         core_active;
   integer       rdy1_cnt, rdy2_cnt;

   sonata_reg_top dut0 (.*);
   sonata_reg_monitor mon0 (.*);

   always #10 usb_clk = ~usb_clk;

   function automatic logic [127:0] random_word128();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   task automatic host_access(input logic [7:0] a, input logic [6:0] bc, input logic [7:0] d,
                              input logic wr);
      @(posedge usb_clk);
      reg_address_i   <= a;
      reg_bytecnt_i   <= bc;
      write_data_i    <= d;
      reg_write_i     <= wr;
      reg_read_i      <= !wr;
      reg_addrvalid_i <= 1'b1;
      @(posedge usb_clk);
      reg_write_i     <= 1'b0;
      reg_read_i      <= 1'b0;
      reg_addrvalid_i <= 1'b0;
   endtask

   task automatic timeout_fail(input string why);
      $display("timeout while waiting for %s", why);
      $display("TESTS FAILED");
      $finish;
   endtask

   task automatic wait_for_core(input logic level);
      integer n;
      n = 0;
      while (core_active !== level && n < 100) begin
         @(posedge usb_clk);
         n++;
      end
      if (core_active !== level) timeout_fail("the crypto core");
   endtask

   task automatic wait_ready(input integer t1, input integer t2);
      integer n;
      n = 0;
      while ((rdy1_cnt < t1 || rdy2_cnt < t2) && n < 100) begin
         @(posedge usb_clk);
         n++;
      end
      if (rdy1_cnt < t1 || rdy2_cnt < t2) timeout_fail("memory read ready");
      @(posedge usb_clk);
   endtask

   // load data and address, then fire the action with address byte 3
   task automatic lb_cycle(input logic [3:0] action);
      integer b;
      n1 = rdy1_cnt + action[1];
      n2 = rdy2_cnt + action[3];
      host_access(`SONATA_REG_LB_ACTION, 0, {4'h0, action}, 1);
      for (b = 0; b < 4; b++) begin
         host_access(`SONATA_REG_LB_DATA1, b, $random(seed), 1);
         host_access(`SONATA_REG_LB_DATA2, b, $random(seed), 1);
      end
      for (b = 0; b < 4; b++)
         host_access(`SONATA_REG_LB_ADDR, b, $random(seed), 1);
      wait_ready(n1, n2);
   endtask

   ////////////////////////////////////////////////////////////
   // crypto core and memory port models
   ////////////////////////////////////////////////////////////

   initial begin
      core_active = 1'b0;
      forever begin
         @(posedge usb_clk);
         if (crypt_start_o === 1'b1) begin
            core_active = 1'b1;
            crypt_busy_i <= 1'b1;
            repeat (2 + ($random(seed) & 7)) @(posedge usb_clk);
            crypt_busy_i      <= 1'b0;
            crypt_done_i      <= 1'b1;
            crypt_textout_i   <= crypt_textin_o ^ crypt_key_o;
            crypt_cipherout_i <= ~crypt_textin_o;
            repeat (2) @(posedge usb_clk);
            crypt_done_i      <= 1'b0;
            crypt_textout_i   <= random_word128();   // stale values after done
            crypt_cipherout_i <= random_word128();
            core_active = 1'b0;
         end
      end
   end

   initial begin
      forever begin
         @(posedge usb_clk);
         if (lb1_rd_o === 1'b1) begin
            repeat (($random(seed) & 3)) @(posedge usb_clk);
            lb1_rd_rdy_i <= 1'b1;
            lb1_rd_d_i   <= $random(seed);
            @(posedge usb_clk);
            lb1_rd_rdy_i <= 1'b0;
            rdy1_cnt++;
         end
      end
   end

   initial begin
      forever begin
         @(posedge usb_clk);
         if (lb2_rd_o === 1'b1) begin
            repeat (($random(seed) & 3)) @(posedge usb_clk);
            lb2_rd_rdy_i <= 1'b1;
            lb2_rd_d_i   <= $random(seed);
            @(posedge usb_clk);
            lb2_rd_rdy_i <= 1'b0;
            rdy2_cnt++;
         end
      end
   end

   initial begin
      repeat (20000) @(posedge usb_clk);
      $display("simulation ran out of time");
      $display("TESTS FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      seed = 43367;
      reset_i = 1'b1;
      usb_clk = 1'b0;
      reg_address_i = 8'h00;
      reg_bytecnt_i = 7'd0;
      write_data_i = 8'h00;
      {reg_read_i, reg_write_i, reg_addrvalid_i} = 3'b000;
      {crypt_busy_i, crypt_done_i} = 2'b00;
      crypt_textout_i = '0;
      crypt_cipherout_i = '0;
      {lb1_rd_d_i, lb2_rd_d_i, lb1_rd_rdy_i, lb2_rd_rdy_i} = '0;
      rdy1_cnt = 0;
      rdy2_cnt = 0;
      repeat (4) @(posedge usb_clk);
      reset_i <= 1'b0;

      mon0.begin_test("identity_reset");
      host_access(`SONATA_REG_CRYPT_TYPE, 0, 0, 0);
      host_access(`SONATA_REG_CRYPT_REV, 0, 0, 0);
      host_access(`SONATA_REG_IDENTIFY, 0, 0, 0);
      host_access(`SONATA_REG_USER_LED, 0, 0, 0);
      host_access(`SONATA_REG_CRYPT_GO, 0, 0, 0);
      host_access(`SONATA_REG_USER_LED, 0, 8'h01, 1);
      host_access(`SONATA_REG_USER_LED, 0, 0, 0);
      mon0.end_test();

      mon0.begin_test("key_text");
      for (i = 0; i < 16; i++) begin
         host_access(`SONATA_REG_CRYPT_KEY, i, $random(seed), 1);
         host_access(`SONATA_REG_CRYPT_TEXTIN, i, $random(seed), 1);
      end
      for (i = 0; i < 16; i++) begin
         host_access(`SONATA_REG_CRYPT_KEY, i, 0, 0);
         host_access(`SONATA_REG_CRYPT_TEXTIN, i, 0, 0);
      end
      mon0.end_test();

      mon0.begin_test("start_busy");
      for (k = 0; k < 3; k++) begin
         host_access(`SONATA_REG_CRYPT_GO, 0, 8'h01, 1);
         repeat (12) host_access(`SONATA_REG_CRYPT_GO, 0, 0, 0);
         wait_for_core(1'b0);
      end
      mon0.end_test();

      mon0.begin_test("done_capture");
      for (k = 0; k < 3; k++) begin
         host_access(`SONATA_REG_CRYPT_TEXTIN, $random(seed) & 15, $random(seed), 1);
         host_access(`SONATA_REG_CRYPT_GO, 0, 8'h01, 1);
         wait_for_core(1'b1);
         wait_for_core(1'b0);
         for (i = 0; i < 16; i++) begin
            host_access(`SONATA_REG_CRYPT_TEXTOUT, i, 0, 0);
            host_access(`SONATA_REG_CRYPT_CIPHEROUT, i, 0, 0);
         end
      end
      mon0.end_test();

      mon0.begin_test("lb_write");
      for (k = 0; k < 6; k++) begin
         act = $random(seed);
         lb_cycle(act);
      end
      mon0.end_test();

      mon0.begin_test("lb_read");
      for (k = 0; k < 4; k++) begin
         act = $random(seed);
         lb_cycle(act | 4'b1010);
         for (i = 0; i < 4; i++) begin
            host_access(`SONATA_REG_LB_DATA1, i, 0, 0);
            host_access(`SONATA_REG_LB_DATA2, i, 0, 0);
         end
      end
      mon0.end_test();

      repeat (4) @(posedge usb_clk);
      mon0.report_summary();
      if (mon0.err_cnt == 0 && dut0.chk0.assert_fail_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- include/sonata_consts.svh
`ifndef SONATA_CONSTS_SVH
`define SONATA_CONSTS_SVH

// bus and data widths
`define SONATA_BYTECNT_W        7
`define SONATA_TEXT_W           128
`define SONATA_LB_W             32

// identity bytes, read only
`define SONATA_CRYPT_TYPE       8'h02
`define SONATA_CRYPT_REV        8'h04
`define SONATA_IDENTIFY         8'h2e

// register map
`define SONATA_REG_USER_LED        8'h01
`define SONATA_REG_CRYPT_TYPE      8'h02
`define SONATA_REG_CRYPT_REV       8'h03
`define SONATA_REG_IDENTIFY        8'h04
`define SONATA_REG_CRYPT_GO        8'h05
`define SONATA_REG_CRYPT_TEXTIN    8'h06
`define SONATA_REG_CRYPT_TEXTOUT   8'h08
`define SONATA_REG_CRYPT_CIPHEROUT 8'h09
`define SONATA_REG_CRYPT_KEY       8'h0a
`define SONATA_REG_LB_DATA1        8'h10
`define SONATA_REG_LB_DATA2        8'h11
`define SONATA_REG_LB_ADDR         8'h12
`define SONATA_REG_LB_ACTION       8'h13

// reset values of the control registers
`define SONATA_USER_LED_RST     1'b0
`define SONATA_LB_ACTION_RST    4'h0

`endif

//--- logic/lb_pkg.sv
`include "sonata_consts.svh"

package lb_pkg;

   // bit 0 up: port 1 write, port 1 read, port 2 write, port 2 read
   typedef struct packed {
      logic lb2_rd;
      logic lb2_wr;
      logic lb1_rd;
      logic lb1_wr;
   } lb_action_t;

   // the pair of port words, seen either as host bytes or as two port words
   typedef union packed {
      logic [7:0][7:0] bytes;       // byte n at bits 8n+7..8n
      struct packed {
         logic [`SONATA_LB_W-1:0] p2;
         logic [`SONATA_LB_W-1:0] p1;
      } port;
   } lb_data_u;

endpackage

//--- logic/reg_map_pkg.sv
package reg_map_pkg;

   // one bit per register, exactly one set on a decoded access
   typedef struct packed {
      logic user_led;
      logic crypt_type;
      logic crypt_rev;
      logic identify;
      logic crypt_go;         // write fires start, read gives busy
      logic crypt_key;
      logic crypt_textin;
      logic crypt_textout;    // captured on done
      logic crypt_cipherout;  // captured on done
      logic lb_data1;         // port 1 word, bytes 0..3
      logic lb_data2;         // port 2 word, bytes 4..7 of the pair
      logic lb_addr;          // byte 3 write launches the action
      logic lb_action;
   } reg_sel_t;

endpackage

//--- logic/sonata_reg_decode.sv
`timescale 1ns/1ps
`include "sonata_consts.svh"

module sonata_reg_decode
   import reg_map_pkg::*;
(
   input  logic [7:0]  reg_address_i,
   input  logic        reg_addrvalid_i,
   input  logic        reg_read_i,
   input  logic        reg_write_i,
   output reg_sel_t    wr_sel_o,
   output reg_sel_t    rd_sel_o
);

   reg_sel_t hit;   // raw address match, not yet qualified

   always_comb begin
      hit = '0;
      case (reg_address_i)
         `SONATA_REG_USER_LED:        hit.user_led        = 1'b1;
         `SONATA_REG_CRYPT_TYPE:      hit.crypt_type      = 1'b1;
         `SONATA_REG_CRYPT_REV:       hit.crypt_rev       = 1'b1;
         `SONATA_REG_IDENTIFY:        hit.identify        = 1'b1;
         `SONATA_REG_CRYPT_GO:        hit.crypt_go        = 1'b1;
         `SONATA_REG_CRYPT_KEY:       hit.crypt_key       = 1'b1;
         `SONATA_REG_CRYPT_TEXTIN:    hit.crypt_textin    = 1'b1;
         `SONATA_REG_CRYPT_TEXTOUT:   hit.crypt_textout   = 1'b1;
         `SONATA_REG_CRYPT_CIPHEROUT: hit.crypt_cipherout = 1'b1;
         `SONATA_REG_LB_DATA1:        hit.lb_data1        = 1'b1;
         `SONATA_REG_LB_DATA2:        hit.lb_data2        = 1'b1;
         `SONATA_REG_LB_ADDR:         hit.lb_addr         = 1'b1;
         `SONATA_REG_LB_ACTION:       hit.lb_action       = 1'b1;
         default:                     hit = '0;   // unmapped
      endcase
   end

   // qualifiers applied here only
   always_comb begin
      wr_sel_o = '0;
      rd_sel_o = '0;
      if (reg_addrvalid_i && reg_write_i)
         wr_sel_o = hit;
      if (reg_addrvalid_i && reg_read_i)
         rd_sel_o = hit;
   end

endmodule

//--- logic/sonata_reg_execute.sv
`timescale 1ns/1ps
`include "sonata_consts.svh"

module sonata_reg_execute
   import reg_map_pkg::*;
   import lb_pkg::*;
(
   input  logic                          usb_clk,
   input  logic                          reset_i,
   input  reg_sel_t                      wr_sel_i,
   input  logic [`SONATA_BYTECNT_W-1:0]  reg_bytecnt_i,
   input  logic [7:0]                    write_data_i,

   input  logic                          crypt_busy_i,
   input  logic                          crypt_done_i,
   input  logic [`SONATA_TEXT_W-1:0]     crypt_textout_i,
   input  logic [`SONATA_TEXT_W-1:0]     crypt_cipherout_i,

   input  logic [`SONATA_LB_W-1:0]       lb1_rd_d_i,
   input  logic                          lb1_rd_rdy_i,
   input  logic [`SONATA_LB_W-1:0]       lb2_rd_d_i,
   input  logic                          lb2_rd_rdy_i,

   output logic                          user_led_o,
   output logic [`SONATA_TEXT_W-1:0]     crypt_key_o,
   output logic [`SONATA_TEXT_W-1:0]     crypt_textin_o,
   output logic                          crypt_start_o,
   output logic                          busy_q_o,
   output logic [`SONATA_TEXT_W-1:0]     textout_q_o,
   output logic [`SONATA_TEXT_W-1:0]     cipherout_q_o,
   output lb_data_u                      lb_rd_data_o,

   output logic [`SONATA_LB_W-1:0]       lb_addr_o,
   output logic [`SONATA_LB_W-1:0]       lb1_wr_d_o,
   output logic [`SONATA_LB_W-1:0]       lb2_wr_d_o,
   output logic                          lb1_wr_o,
   output logic                          lb1_rd_o,
   output logic                          lb2_wr_o,
   output logic                          lb2_rd_o
);

   lb_data_u    lb_wr_q;        // write words for both ports
   lb_action_t  action_q;
   logic        done_q;
   logic        done_rise;
   logic        lb_fire;        // address byte 3 written this cycle

   assign done_rise = crypt_done_i & ~done_q;
   assign lb_fire   = wr_sel_i.lb_addr && (reg_bytecnt_i == 'd3);

   assign lb1_wr_d_o = lb_wr_q.port.p1;
   assign lb2_wr_d_o = lb_wr_q.port.p2;

   ////////////////////////////////////////////////////////////
   // control state and strobes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         user_led_o    <= `SONATA_USER_LED_RST;
         action_q      <= lb_action_t'(`SONATA_LB_ACTION_RST);
         crypt_start_o <= 1'b0;
         busy_q_o      <= 1'b0;
         done_q        <= 1'b0;
         lb1_wr_o      <= 1'b0;
         lb1_rd_o      <= 1'b0;
         lb2_wr_o      <= 1'b0;
         lb2_rd_o      <= 1'b0;
      end else begin
         if (wr_sel_i.user_led)
            user_led_o <= write_data_i[0];
         if (wr_sel_i.lb_action)
            action_q <= lb_action_t'(write_data_i[3:0]);

         crypt_start_o <= wr_sel_i.crypt_go;   // one cycle per go write
         busy_q_o      <= crypt_busy_i;
         done_q        <= crypt_done_i;

         // each enabled port gets a single pulse
         lb1_wr_o <= lb_fire & action_q.lb1_wr;
         lb1_rd_o <= lb_fire & action_q.lb1_rd;
         lb2_wr_o <= lb_fire & action_q.lb2_wr;
         lb2_rd_o <= lb_fire & action_q.lb2_rd;
      end
   end

   ////////////////////////////////////////////////////////////
   // byte-wide data registers and captures
   ////////////////////////////////////////////////////////////

   always_ff @(posedge usb_clk) begin
      if (wr_sel_i.crypt_key)
         crypt_key_o[reg_bytecnt_i*8 +: 8] <= write_data_i;
      if (wr_sel_i.crypt_textin)
         crypt_textin_o[reg_bytecnt_i*8 +: 8] <= write_data_i;
      if (wr_sel_i.lb_data1)
         lb_wr_q.bytes[reg_bytecnt_i] <= write_data_i;
      if (wr_sel_i.lb_data2)
         lb_wr_q.bytes[reg_bytecnt_i + 4] <= write_data_i;   // upper word
      if (wr_sel_i.lb_addr)
         lb_addr_o[reg_bytecnt_i*8 +: 8] <= write_data_i;

      // core results, sampled once per done pulse
      if (done_rise) begin
         textout_q_o   <= crypt_textout_i;
         cipherout_q_o <= crypt_cipherout_i;
      end

      if (lb1_rd_rdy_i)
         lb_rd_data_o.port.p1 <= lb1_rd_d_i;
      if (lb2_rd_rdy_i)
         lb_rd_data_o.port.p2 <= lb2_rd_d_i;
   end

endmodule

//--- logic/sonata_reg_result.sv
`timescale 1ns/1ps
`include "sonata_consts.svh"

module sonata_reg_result
   import reg_map_pkg::*;
   import lb_pkg::*;
(
   input  reg_sel_t                      rd_sel_i,
   input  logic [`SONATA_BYTECNT_W-1:0]  reg_bytecnt_i,
   input  logic                          user_led_i,
   input  logic                          busy_q_i,
   input  logic [`SONATA_TEXT_W-1:0]     crypt_key_i,
   input  logic [`SONATA_TEXT_W-1:0]     crypt_textin_i,
   input  logic [`SONATA_TEXT_W-1:0]     textout_q_i,
   input  logic [`SONATA_TEXT_W-1:0]     cipherout_q_i,
   input  lb_data_u                      lb_rd_data_i,
   output logic [7:0]                    read_data_o
);

   // combinational read mux, valid in the read cycle itself
   always_comb begin
      case (1'b1)
         rd_sel_i.user_led:
            read_data_o = {7'b0, user_led_i};
         rd_sel_i.crypt_type:
            read_data_o = `SONATA_CRYPT_TYPE;
         rd_sel_i.crypt_rev:
            read_data_o = `SONATA_CRYPT_REV;
         rd_sel_i.identify:
            read_data_o = `SONATA_IDENTIFY;
         rd_sel_i.crypt_go:
            read_data_o = {7'b0, busy_q_i};   // busy, one cycle late
         rd_sel_i.crypt_key:
            read_data_o = crypt_key_i[reg_bytecnt_i*8 +: 8];
         rd_sel_i.crypt_textin:
            read_data_o = crypt_textin_i[reg_bytecnt_i*8 +: 8];
         rd_sel_i.crypt_textout:
            read_data_o = textout_q_i[reg_bytecnt_i*8 +: 8];
         rd_sel_i.crypt_cipherout:
            read_data_o = cipherout_q_i[reg_bytecnt_i*8 +: 8];
         rd_sel_i.lb_data1:
            read_data_o = lb_rd_data_i.bytes[reg_bytecnt_i];
         rd_sel_i.lb_data2:
            read_data_o = lb_rd_data_i.bytes[reg_bytecnt_i + 4];  // port 2 word
         default:
            read_data_o = 8'h00;   // no select, or write-only register
      endcase
   end

endmodule

//--- logic/sonata_reg_top.sv
`timescale 1ns/1ps
`include "sonata_consts.svh"

module sonata_reg_top
   import reg_map_pkg::*;
   import lb_pkg::*;
(
   input  logic                          usb_clk,
   input  logic                          reset_i,

   // host register bus
   input  logic [7:0]                    reg_address_i,
   input  logic [`SONATA_BYTECNT_W-1:0]  reg_bytecnt_i,
   input  logic [7:0]                    write_data_i,
   output logic [7:0]                    read_data_o,
   input  logic                          reg_read_i,
   input  logic                          reg_write_i,
   input  logic                          reg_addrvalid_i,

   // crypto core
   output logic                          user_led_o,
   output logic [`SONATA_TEXT_W-1:0]     crypt_key_o,
   output logic [`SONATA_TEXT_W-1:0]     crypt_textin_o,
   output logic                          crypt_start_o,
   input  logic                          crypt_busy_i,
   input  logic                          crypt_done_i,
   input  logic [`SONATA_TEXT_W-1:0]     crypt_textout_i,
   input  logic [`SONATA_TEXT_W-1:0]     crypt_cipherout_i,

   // local-bus memory ports
   output logic [`SONATA_LB_W-1:0]       lb_addr_o,
   output logic [`SONATA_LB_W-1:0]       lb1_wr_d_o,
   output logic [`SONATA_LB_W-1:0]       lb2_wr_d_o,
   output logic                          lb1_wr_o,
   output logic                          lb1_rd_o,
   output logic                          lb2_wr_o,
   output logic                          lb2_rd_o,
   input  logic [`SONATA_LB_W-1:0]       lb1_rd_d_i,
   input  logic                          lb1_rd_rdy_i,
   input  logic [`SONATA_LB_W-1:0]       lb2_rd_d_i,
   input  logic                          lb2_rd_rdy_i
);

   reg_sel_t                     wr_sel;
   reg_sel_t                     rd_sel;
   logic                         busy_q;
   logic [`SONATA_TEXT_W-1:0]    textout_q;
   logic [`SONATA_TEXT_W-1:0]    cipherout_q;
   lb_data_u                     lb_rd_data;

   sonata_reg_decode u_decode (
      .reg_address_i   (reg_address_i),
      .reg_addrvalid_i (reg_addrvalid_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .wr_sel_o        (wr_sel),
      .rd_sel_o        (rd_sel)
   );

   sonata_reg_execute u_execute (
      .usb_clk           (usb_clk),
      .reset_i           (reset_i),
      .wr_sel_i          (wr_sel),
      .reg_bytecnt_i     (reg_bytecnt_i),
      .write_data_i      (write_data_i),
      .crypt_busy_i      (crypt_busy_i),
      .crypt_done_i      (crypt_done_i),
      .crypt_textout_i   (crypt_textout_i),
      .crypt_cipherout_i (crypt_cipherout_i),
      .lb1_rd_d_i        (lb1_rd_d_i),
      .lb1_rd_rdy_i      (lb1_rd_rdy_i),
      .lb2_rd_d_i        (lb2_rd_d_i),
      .lb2_rd_rdy_i      (lb2_rd_rdy_i),
      .user_led_o        (user_led_o),
      .crypt_key_o       (crypt_key_o),
      .crypt_textin_o    (crypt_textin_o),
      .crypt_start_o     (crypt_start_o),
      .busy_q_o          (busy_q),
      .textout_q_o       (textout_q),
      .cipherout_q_o     (cipherout_q),
      .lb_rd_data_o      (lb_rd_data),
      .lb_addr_o         (lb_addr_o),
      .lb1_wr_d_o        (lb1_wr_d_o),
      .lb2_wr_d_o        (lb2_wr_d_o),
      .lb1_wr_o          (lb1_wr_o),
      .lb1_rd_o          (lb1_rd_o),
      .lb2_wr_o          (lb2_wr_o),
      .lb2_rd_o          (lb2_rd_o)
   );

   sonata_reg_result u_result (
      .rd_sel_i        (rd_sel),
      .reg_bytecnt_i   (reg_bytecnt_i),
      .user_led_i      (user_led_o),
      .busy_q_i        (busy_q),
      .crypt_key_i     (crypt_key_o),
      .crypt_textin_i  (crypt_textin_o),
      .textout_q_i     (textout_q),
      .cipherout_q_i   (cipherout_q),
      .lb_rd_data_i    (lb_rd_data),
      .read_data_o     (read_data_o)
   );

endmodule

//--- src.f
+incdir+include
logic/reg_map_pkg.sv
logic/lb_pkg.sv
logic/sonata_reg_decode.sv
logic/sonata_reg_execute.sv
logic/sonata_reg_result.sv
logic/sonata_reg_top.sv
bench/sonata_reg_chk.sv
bench/sonata_reg_monitor.sv
bench/sonata_reg_tb.sv
